// File: hbm_channel_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "hbm_consts.svh"

module hbm_channel_model
    import hbm_pkg::*;
(
    input  wire          axi3_if,
    input  wire          rst,
    input  wire          aw_valid,
    input  wire hbm_aw_t aw,
    input  wire          w_valid,
    input  wire hbm_w_t  w,
    input  wire          ar_valid,
    input  wire hbm_aw_t ar,
    output logic         b_valid,
    output hbm_b_t       b,
    output logic         r_valid,
    output hbm_r_t       r
);

    typedef logic [`HBM_ROW_WID-1:0] row_t;

    // One row per 32-byte beat, wrapping on the depth
    hbm_data_t                  ram [`HBM_DEPTH_ROWS];
    logic [`HBM_DEPTH_ROWS-1:0] row_valid;

    hbm_addr_t aw_addr_q;
    hbm_id_t   aw_id_q;
    hbm_addr_t wr_addr;
    hbm_id_t   wr_id;
    row_t      wr_row;

    row_t      ar_row_q;
    hbm_id_t   ar_id_q;
    row_t      rd_row;
    logic      rd_second;

    function automatic row_t addr_to_row(input hbm_addr_t addr);
        return addr[`HBM_BEAT_OFFS_WID +: `HBM_ROW_WID];
    endfunction

    // ========================================
    // Write path
    // ========================================
    always_ff @(posedge axi3_if) begin
        if (aw_valid) begin
            aw_addr_q <= aw.addr;
            aw_id_q   <= aw.id;
        end
    end

    // Beat 0 arrives together with the address
    assign wr_addr = aw_valid ? aw.addr : aw_addr_q;
    assign wr_id   = aw_valid ? aw.id : aw_id_q;

    // Last beat goes one row above the burst base
    assign wr_row = addr_to_row(wr_addr) + row_t'(w.last);

    always_ff @(posedge axi3_if) begin
        if (w_valid) begin
            ram[wr_row] <= w.data;
        end
    end

    always_ff @(posedge axi3_if) begin
        if (rst) begin
            row_valid <= '0;
        end else if (w_valid) begin
            row_valid[wr_row] <= 1'b1;
        end
    end

    // One response per burst
    always_ff @(posedge axi3_if) begin
        if (rst) begin
            b_valid <= 1'b0;
        end else begin
            b_valid <= w_valid && w.last;
        end
    end

    always_ff @(posedge axi3_if) begin
        if (w_valid && w.last) begin
            b.id   <= wr_id;
            b.resp <= HBM_RESP_OKAY;
        end
    end

    // ========================================
    // Read path
    // ========================================
    always_ff @(posedge axi3_if) begin
        if (ar_valid) begin
            ar_row_q <= addr_to_row(ar.addr);
            ar_id_q  <= ar.id;
        end
    end

    // Second beat follows right after the first
    assign rd_second = r_valid && !r.last;
    assign rd_row    = ar_valid ? addr_to_row(ar.addr) : ar_row_q + 1'b1;

    // Last is qualified here so it is only high on the final beat
    always_ff @(posedge axi3_if) begin
        if (rst) begin
            r_valid <= 1'b0;
            r.last  <= 1'b0;
        end else begin
            r_valid <= ar_valid || rd_second;
            r.last  <= rd_second && !ar_valid;
        end
    end

    // Rows never written read back as zero
    always_ff @(posedge axi3_if) begin
        if (ar_valid || rd_second) begin
            r.data <= row_valid[rd_row] ? ram[rd_row] : '0;
            r.id   <= ar_valid ? ar.id : ar_id_q;
            r.resp <= HBM_RESP_OKAY;
        end
    end

    // ========================================
    // Checks
    // ========================================
    a_aw_aligned: assert property (@(posedge axi3_if) disable iff (rst)
        aw_valid |-> aw.addr[`HBM_BEAT_OFFS_WID-1:0] == '0)
        else $error("write address not beat aligned");

    a_ar_aligned: assert property (@(posedge axi3_if) disable iff (rst)
        ar_valid |-> ar.addr[`HBM_BEAT_OFFS_WID-1:0] == '0)
        else $error("read address not beat aligned");

    // First beat rides with the address and is never last
    a_w_two_beats: assert property (@(posedge axi3_if) disable iff (rst)
        aw_valid |-> (w_valid && !w.last) ##1 (w_valid && w.last))
        else $error("write burst is not two beats");

endmodule

`default_nettype wire

// File: hbm_consts.svh
`ifndef HBM_CONSTS_SVH
`define HBM_CONSTS_SVH

// ========================================
// Channel geometry
// ========================================
`define HBM_ADDR_WID 33
`define HBM_BEAT_BYTES 32
`define HBM_ID_WID 6
`define HBM_ENTRY_BEATS 2

// Derived beat sizes
`define HBM_BEAT_WID (`HBM_BEAT_BYTES * 8)
`define HBM_BEAT_OFFS_WID ($clog2(`HBM_BEAT_BYTES))

// ========================================
// Entry store
// ========================================
`define HBM_DEPTH_ENTRIES 64
`define HBM_ENTRY_IDX_WID 6
`define HBM_ENTRY_WID (`HBM_ENTRY_BEATS * `HBM_BEAT_WID)
`define HBM_ENTRY_OFFS_WID ($clog2(`HBM_ENTRY_BEATS * `HBM_BEAT_BYTES))
`define HBM_DEPTH_ROWS (`HBM_DEPTH_ENTRIES * `HBM_ENTRY_BEATS)
`define HBM_ROW_WID ($clog2(`HBM_DEPTH_ROWS))

`endif

// File: hbm_entry_client.sv
`timescale 1ns/10ps
`default_nettype none

`include "hbm_consts.svh"

module hbm_entry_client
    import hbm_pkg::*;
(
    input  wire             axi3_if,
    input  wire             rst,
    input  wire             cmd_valid,
    input  wire entry_cmd_t cmd,
    input  wire             b_valid,
    input  wire hbm_b_t     b,
    input  wire             r_last_seen,
    output logic            busy,
    output logic            aw_valid,
    output hbm_aw_t         aw,
    output logic            w_valid,
    output hbm_w_t          w,
    output logic            ar_valid,
    output hbm_aw_t         ar,
    output logic            wr_done,
    output hbm_id_t         wr_tag
);

    client_state_t state;
    client_state_t state_next;

    logic      start;
    logic      start_wr;
    logic      start_rd;
    logic      resp_seen;
    hbm_addr_t entry_addr;
    hbm_data_t beat1_q;

    assign start     = cmd_valid && (state == CLIENT_IDLE);
    assign start_wr  = start && (cmd.op == ENTRY_WRITE);
    assign start_rd  = start && (cmd.op == ENTRY_READ);
    assign resp_seen = b_valid && (state == CLIENT_WAIT_RESP);

    // Entry index times 64
    assign entry_addr = hbm_addr_t'({cmd.index, {`HBM_ENTRY_OFFS_WID{1'b0}}});

    // ========================================
    // FSM
    // ========================================
    always_comb begin
        state_next = state;
        case (state)
            CLIENT_IDLE: begin
                if (start_wr) begin
                    state_next = CLIENT_WR_BEAT1;
                end else if (start_rd) begin
                    state_next = CLIENT_WAIT_READ;
                end
            end
            CLIENT_WR_BEAT1: begin
                state_next = CLIENT_WAIT_RESP;
            end
            CLIENT_WAIT_RESP: begin
                if (b_valid) begin
                    state_next = CLIENT_IDLE;
                end
            end
            CLIENT_WAIT_READ: begin
                if (r_last_seen) begin
                    state_next = CLIENT_IDLE;
                end
            end
            default: begin
                state_next = CLIENT_IDLE;
            end
        endcase
    end

    always_ff @(posedge axi3_if) begin
        if (rst) begin
            state <= CLIENT_IDLE;
            busy  <= 1'b0;
        end else begin
            state <= state_next;
            // Lags the FSM by a cycle so it still covers the done pulse
            busy  <= (state != CLIENT_IDLE) || (state_next != CLIENT_IDLE);
        end
    end

    // ========================================
    // Channel strobes
    // ========================================
    always_ff @(posedge axi3_if) begin
        if (rst) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            ar_valid <= 1'b0;
            wr_done  <= 1'b0;
        end else begin
            aw_valid <= start_wr;
            w_valid  <= start_wr || (state == CLIENT_WR_BEAT1);
            ar_valid <= start_rd;
            wr_done  <= resp_seen;
        end
    end

    always_ff @(posedge axi3_if) begin
        if (start) begin
            aw.addr <= entry_addr;
            aw.id   <= cmd.tag;
            ar.addr <= entry_addr;
            ar.id   <= cmd.tag;
            // Upper half waits for the second beat
            beat1_q <= cmd.data[`HBM_ENTRY_WID-1:`HBM_BEAT_WID];
        end
        if (start_wr) begin
            w.data <= cmd.data[`HBM_BEAT_WID-1:0];
            w.last <= 1'b0;
        end else if (state == CLIENT_WR_BEAT1) begin
            w.data <= beat1_q;
            w.last <= 1'b1;
        end
        if (resp_seen) begin
            wr_tag <= b.id;
        end
    end

    // ========================================
    // Checks
    // ========================================
    a_no_cmd_while_busy: assert property (@(posedge axi3_if) disable iff (rst)
        cmd_valid |-> !busy)
        else $error("command issued while busy");

    a_b_when_waiting: assert property (@(posedge axi3_if) disable iff (rst)
        b_valid |-> (state == CLIENT_WAIT_RESP) && (b.resp == HBM_RESP_OKAY))
        else $error("unexpected write response");

endmodule

`default_nettype wire

// File: hbm_pkg.sv
`default_nettype none

`include "hbm_consts.svh"

package hbm_pkg;

    // ========================================
    // Plain widths
    // ========================================
    typedef logic [`HBM_ADDR_WID-1:0]      hbm_addr_t;
    typedef logic [`HBM_BEAT_WID-1:0]      hbm_data_t;
    // Beat 0 sits in the low half
    typedef logic [`HBM_ENTRY_WID-1:0]     hbm_entry_t;
    typedef logic [`HBM_ID_WID-1:0]        hbm_id_t;
    typedef logic [`HBM_ENTRY_IDX_WID-1:0] entry_idx_t;

    // ========================================
    // Encodings
    // ========================================
    // The channel never fails, so only OKAY is ever returned
    typedef enum logic [1:0] {
        HBM_RESP_OKAY = 2'b00
    } hbm_resp_t;

    typedef enum logic {
        ENTRY_READ  = 1'b0,
        ENTRY_WRITE = 1'b1
    } entry_op_t;

    typedef enum logic [1:0] {
        CLIENT_IDLE,
        CLIENT_WR_BEAT1,
        CLIENT_WAIT_RESP,
        CLIENT_WAIT_READ
    } client_state_t;

    // ========================================
    // Bundles
    // ========================================
    typedef struct packed {
        entry_op_t  op;
        entry_idx_t index;
        hbm_id_t    tag;
        hbm_entry_t data;
    } entry_cmd_t;

    // Shared by write address and read address
    typedef struct packed {
        hbm_addr_t addr;
        hbm_id_t   id;
    } hbm_aw_t;

    typedef struct packed {
        hbm_data_t data;
        logic      last;
    } hbm_w_t;

    typedef struct packed {
        hbm_id_t   id;
        hbm_resp_t resp;
    } hbm_b_t;

    typedef struct packed {
        hbm_data_t data;
        hbm_id_t   id;
        hbm_resp_t resp;
        logic      last;
    } hbm_r_t;

endpackage

`default_nettype wire

// File: hbm_read_assembler.sv
`timescale 1ns/10ps
`default_nettype none

`include "hbm_consts.svh"

module hbm_read_assembler
    import hbm_pkg::*;
(
    input  wire         axi3_if,
    input  wire         rst,
    input  wire         r_valid,
    input  wire hbm_r_t r,
    output logic        rd_valid,
    output hbm_entry_t  rd_entry,
    output hbm_id_t     rd_tag
);

    hbm_data_t beat0_q;
    logic      first_beat;
    logic      last_beat;

    assign first_beat = r_valid && !r.last;
    assign last_beat  = r_valid && r.last;

    // ========================================
    // Beat capture
    // ========================================
    always_ff @(posedge axi3_if) begin
        if (first_beat) begin
            beat0_q <= r.data;
        end
    end

    always_ff @(posedge axi3_if) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= last_beat;
        end
    end

    // Beat 0 in the low half
    always_ff @(posedge axi3_if) begin
        if (last_beat) begin
            rd_entry <= {r.data, beat0_q};
            rd_tag   <= r.id;
        end
    end

    // ========================================
    // Checks
    // ========================================
    // Both beats of a burst carry the same id
    a_same_id: assert property (@(posedge axi3_if) disable iff (rst)
        first_beat |=> last_beat && (r.id == $past(r.id)))
        else $error("read burst id changed between beats");

endmodule

`default_nettype wire

// File: hbm_state_store_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "hbm_consts.svh"

module hbm_state_store_top
    import hbm_pkg::*;
(
    input  wire             axi3_if,
    input  wire             rst,
    input  wire             cmd_valid,
    input  wire entry_cmd_t cmd,
    output wire             busy,
    output wire             wr_done,
    output wire hbm_id_t    wr_tag,
    output wire             rd_valid,
    output wire hbm_entry_t rd_entry,
    output wire hbm_id_t    rd_tag
);

    // ========================================
    // Channel wires
    // ========================================
    logic    aw_valid;
    hbm_aw_t aw;
    logic    w_valid;
    hbm_w_t  w;
    logic    ar_valid;
    hbm_aw_t ar;
    logic    b_valid;
    hbm_b_t  b;
    logic    r_valid;
    hbm_r_t  r;

    hbm_entry_client hbm_entry_client_i (
        .axi3_if     (axi3_if),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .b_valid     (b_valid),
        .b           (b),
        // Last is only high on the final read beat
        .r_last_seen (r.last),
        .busy        (busy),
        .aw_valid    (aw_valid),
        .aw          (aw),
        .w_valid     (w_valid),
        .w           (w),
        .ar_valid    (ar_valid),
        .ar          (ar),
        .wr_done     (wr_done),
        .wr_tag      (wr_tag)
    );

    hbm_channel_model hbm_channel_model_i (
        .axi3_if  (axi3_if),
        .rst      (rst),
        .aw_valid (aw_valid),
        .aw       (aw),
        .w_valid  (w_valid),
        .w        (w),
        .ar_valid (ar_valid),
        .ar       (ar),
        .b_valid  (b_valid),
        .b        (b),
        .r_valid  (r_valid),
        .r        (r)
    );

    hbm_read_assembler hbm_read_assembler_i (
        .axi3_if  (axi3_if),
        .rst      (rst),
        .r_valid  (r_valid),
        .r        (r),
        .rd_valid (rd_valid),
        .rd_entry (rd_entry),
        .rd_tag   (rd_tag)
    );

endmodule

`default_nettype wire

// File: list.f
+incdir+.
hbm_pkg.sv
hbm_channel_model.sv
hbm_entry_client.sv
hbm_read_assembler.sv
hbm_state_store_top.sv
tb_hbm_state_store.sv

// File: tb_hbm_state_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "hbm_consts.svh"

module tb_hbm_state_store
    import hbm_pkg::*;
();

    localparam int NUM_ROWS        = 15;
    localparam int RESET_CYCLES    = 10;
    localparam int LATENCY         = 4;
    localparam int WATCHDOG_CYCLES = NUM_ROWS * 10 + RESET_CYCLES;

    // Index is wider than the DUT field so rows can alias past the depth
    typedef struct packed {
        entry_op_t  op;
        logic [7:0] index;
        hbm_id_t    tag;
        hbm_entry_t data;
    } stim_row_t;

    logic       axi3_if;
    logic       rst;
    logic       cmd_valid;
    entry_cmd_t cmd;
    logic       busy;
    logic       wr_done;
    hbm_id_t    wr_tag;
    logic       rd_valid;
    hbm_entry_t rd_entry;
    hbm_id_t    rd_tag;

    integer     seed;
    stim_row_t  table_rows [NUM_ROWS];
    hbm_entry_t shadow [`HBM_DEPTH_ENTRIES];

    hbm_state_store_top hbm_state_store_top_i (
        .axi3_if   (axi3_if),
        .rst       (rst),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .wr_done   (wr_done),
        .wr_tag    (wr_tag),
        .rd_valid  (rd_valid),
        .rd_entry  (rd_entry),
        .rd_tag    (rd_tag)
    );

    initial begin
        axi3_if = 1'b0;
        forever #20 axi3_if = ~axi3_if;
    end

    // ========================================
    // Helpers
    // ========================================
    task automatic check_value(input string name, input logic [511:0] got,
                               input logic [511:0] expected);
        if (got !== expected) begin
            $display("Mismatch %s: got %0h expected %0h", name, got, expected);
            $display("sim failed");
            $fatal(1);
        end
    endtask

    // Write rows get fresh random data, read rows carry none
    task automatic add_row(input int n, input entry_op_t op, input int index, input int tag);
        hbm_entry_t data;
        stim_row_t  row;
        int         k;
        data = '0;
        if (op == ENTRY_WRITE) begin
            for (k = 0; k < 16; k++) begin
                data[k*32 +: 32] = $random(seed);
            end
        end
        row.op        = op;
        row.index     = index[7:0];
        row.tag       = tag[`HBM_ID_WID-1:0];
        row.data      = data;
        table_rows[n] = row;
    endtask

    task automatic build_table();
        add_row(0,  ENTRY_READ,  5,   1);
        add_row(1,  ENTRY_WRITE, 5,   2);
        add_row(2,  ENTRY_READ,  5,   3);
        add_row(3,  ENTRY_WRITE, 10,  4);
        // Alias of index 10
        add_row(4,  ENTRY_WRITE, 74,  5);
        add_row(5,  ENTRY_READ,  10,  6);
        add_row(6,  ENTRY_READ,  138, 7);
        add_row(7,  ENTRY_WRITE, 63,  8);
        add_row(8,  ENTRY_WRITE, 0,   9);
        add_row(9,  ENTRY_READ,  63,  10);
        add_row(10, ENTRY_READ,  64,  11);
        // Index 8, never written
        add_row(11, ENTRY_READ,  200, 12);
        add_row(12, ENTRY_WRITE, 5,   13);
        add_row(13, ENTRY_READ,  69,  14);
        add_row(14, ENTRY_READ,  33,  63);
    endtask

    // Called just after a falling edge, returns just after a falling edge
    task automatic apply_row(input int n);
        stim_row_t  row;
        int         slot;
        int         cycles;
        logic       done;
        hbm_entry_t expected;
        row      = table_rows[n];
        slot     = row.index % `HBM_DEPTH_ENTRIES;
        expected = shadow[slot];
        cycles   = 0;
        done     = 1'b0;

        cmd_valid = 1'b1;
        cmd.op    = row.op;
        cmd.index = row.index[`HBM_ENTRY_IDX_WID-1:0];
        cmd.tag   = row.tag;
        cmd.data  = row.data;
        @(posedge axi3_if);

        while (!done) begin
            @(negedge axi3_if);
            cmd_valid = 1'b0;
            cmd       = '0;
            cycles++;
            check_value("busy", busy, 1'b1);
            if (row.op == ENTRY_WRITE) begin
                check_value("rd_valid", rd_valid, 1'b0);
                done = wr_done;
            end else begin
                check_value("wr_done", wr_done, 1'b0);
                done = rd_valid;
            end
        end
        check_value("latency", cycles, LATENCY);

        if (row.op == ENTRY_WRITE) begin
            check_value("wr_tag", wr_tag, row.tag);
            shadow[slot] = row.data;
        end else begin
            check_value("rd_tag", rd_tag, row.tag);
            check_value("rd_entry", rd_entry, expected);
        end

        // Pulses are one cycle wide and busy drops right after
        @(negedge axi3_if);
        check_value("busy", busy, 1'b0);
        check_value("wr_done", wr_done, 1'b0);
        check_value("rd_valid", rd_valid, 1'b0);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int i;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        seed      = 32'h1c62f9fc;
        for (i = 0; i < `HBM_DEPTH_ENTRIES; i++) begin
            shadow[i] = '0;
        end
        build_table();

        for (i = 0; i < RESET_CYCLES; i++) begin
            @(posedge axi3_if);
            @(negedge axi3_if);
            check_value("busy", busy, 1'b0);
            check_value("wr_done", wr_done, 1'b0);
            check_value("rd_valid", rd_valid, 1'b0);
        end
        rst = 1'b0;

        // Outputs stay quiet with no command
        for (i = 0; i < 2; i++) begin
            @(negedge axi3_if);
            check_value("busy", busy, 1'b0);
            check_value("wr_done", wr_done, 1'b0);
            check_value("rd_valid", rd_valid, 1'b0);
        end

        for (i = 0; i < NUM_ROWS; i++) begin
            apply_row(i);
        end

        $display("sim passed");
        $finish;
    end

    // ========================================
    // Watchdog
    // ========================================
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge axi3_if);
        $display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("sim failed");
        $fatal(1);
    end

endmodule

`default_nettype wire
